// ==== hdl/ff_layer_pkg.sv ====
// Forward-forward layer definitions
package ff_layer_pkg;

    // Word size of every datapath value
    parameter int DATA_WIDTH = 32;

    // Q16.16 format, so 16 bits sit below the binary point
    parameter int FRAC_BITS = 16;

    // Signed fixed-point word used for pixels, weights and sums
    typedef logic signed [DATA_WIDTH-1:0] fixed_t;

    // Default layer geometry
    // Pixels per sample, streamed one per strobe
    parameter int INPUT_SIZE = 16;

    // Neuron count, split evenly over two banks
    // Must stay even
    parameter int NUM_NEURONS = 4;

    // Goodness threshold for the positive decision
    // 3.0 in Q16.16
    parameter fixed_t THETA_DEFAULT = 32'sh0003_0000;

    // Handy Q16.16 constants
    // 1.0 in Q16.16
    parameter fixed_t FIXED_ONE = fixed_t'(1) <<< FRAC_BITS;

    // Zero word, used for ReLU clamping
    parameter fixed_t FIXED_ZERO = '0;

    // Sizing notes
    // Sums wrap modulo 2^DATA_WIDTH, nothing saturates
    // Keep pixel and weight magnitudes small enough that
    // the squared activations stay inside the Q16.16 range
    // With inputs within 2.0 and 16 pixels an activation
    // stays below 64.0, and its square below 4096.0

endpackage

// ==== hdl/weight_load_if.sv ====
// Weight write port
`timescale 1ns/1ps
interface weight_load_if #(
    parameter int INPUT_SIZE  = ff_layer_pkg::INPUT_SIZE,
    parameter int NUM_NEURONS = ff_layer_pkg::NUM_NEURONS
);

    // Single-cycle write strobe, one word per cycle
    logic                           we;
    // Global neuron index, each bank picks its own half
    logic [$clog2(NUM_NEURONS)-1:0] neuron;
    // Pixel index within the neuron's weight row
    logic [$clog2(INPUT_SIZE)-1:0]  pixel;
    // Q16.16 weight value
    ff_layer_pkg::fixed_t           data;

    // Top level drives the write
    modport source (output we, output neuron, output pixel, output data);

    // Banks only listen
    modport sink (input we, input neuron, input pixel, input data);

endinterface

// ==== hdl/neuron_bank.sv ====
// Neuron bank MAC and square-sum
`timescale 1ns/1ps
module neuron_bank #(
    parameter int INPUT_SIZE  = ff_layer_pkg::INPUT_SIZE,
    parameter int NUM_NEURONS = ff_layer_pkg::NUM_NEURONS,
    parameter int BANK_ID     = 0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    weight_load_if.sink          wload,
    input  logic                 pixel_valid,
    input  ff_layer_pkg::fixed_t pixel_data,
    output ff_layer_pkg::fixed_t partial,
    output logic                 partial_valid
);

    localparam int DW = ff_layer_pkg::DATA_WIDTH;

    // Neurons owned by this bank
    localparam int HALF = NUM_NEURONS / 2;
    // Local neuron index width, at least one bit
    localparam int HW = (HALF > 1) ? $clog2(HALF) : 1;
    localparam int NW = $clog2(NUM_NEURONS);
    localparam int PW = $clog2(INPUT_SIZE);

    // Global neuron range of this bank, one extra bit so the top bound fits
    localparam logic [NW:0] LO_NEURON = (NW + 1)'(BANK_ID * HALF);
    localparam logic [NW:0] HI_NEURON = (NW + 1)'(BANK_ID * HALF + HALF);

    localparam logic [PW-1:0] LAST_PIX = PW'(INPUT_SIZE - 1);

    // Q16.16 multiply
    // Full signed product, shifted back to 16 fraction bits, low word kept
    function automatic ff_layer_pkg::fixed_t fx_mul(
        input ff_layer_pkg::fixed_t a,
        input ff_layer_pkg::fixed_t b
    );
        logic signed [2*DW-1:0] full;
        full   = (2*DW)'(a) * (2*DW)'(b);
        fx_mul = ff_layer_pkg::fixed_t'(full >>> ff_layer_pkg::FRAC_BITS);
    endfunction

    // Weight registers, one row per local neuron
    ff_layer_pkg::fixed_t weight [HALF][INPUT_SIZE];

    logic [NW:0]     neuron_ext;
    logic            wr_hit;
    logic [HW-1:0]   wr_idx;

    // Pixel position inside the current sample
    logic [PW-1:0]   pix_cnt;

    ff_layer_pkg::fixed_t prod [HALF];
    ff_layer_pkg::fixed_t acc  [HALF];
    ff_layer_pkg::fixed_t act  [HALF];
    ff_layer_pkg::fixed_t sum_sq;

    // High for the cycle after the last pixel was accumulated
    logic            sums_ready;

    // Weight write decode
    assign neuron_ext = {1'b0, wload.neuron};
    assign wr_hit     = wload.we && (neuron_ext >= LO_NEURON) && (neuron_ext < HI_NEURON);
    // Rebase to the local row
    assign wr_idx     = HW'(neuron_ext - LO_NEURON);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < HALF; n++) begin
                for (int p = 0; p < INPUT_SIZE; p++) begin
                    weight[n][p] <= '0;
                end
            end
        end else if (wr_hit) begin
            weight[wr_idx][wload.pixel] <= wload.data;
        end
    end

    // Pixel counter, wraps after the last pixel of a sample
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt    <= '0;
            sums_ready <= 1'b0;
        end else begin
            sums_ready <= pixel_valid && (pix_cnt == LAST_PIX);
            if (pixel_valid) begin
                pix_cnt <= (pix_cnt == LAST_PIX) ? '0 : pix_cnt + 1'b1;
            end
        end
    end

    // One multiplier per neuron, all fed the same pixel
    always_comb begin
        for (int n = 0; n < HALF; n++) begin
            prod[n] = fx_mul(pixel_data, weight[n][pix_cnt]);
        end
    end

    // Accumulate per neuron
    // Pixel 0 loads fresh so the next sample can follow right away
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < HALF; n++) begin
                acc[n] <= '0;
            end
        end else if (pixel_valid) begin
            for (int n = 0; n < HALF; n++) begin
                acc[n] <= (pix_cnt == '0) ? prod[n] : acc[n] + prod[n];
            end
        end
    end

    // Second stage
    // ReLU clamps negative sums, then square and sum over the bank
    always_comb begin
        sum_sq = '0;
        for (int n = 0; n < HALF; n++) begin
            act[n] = acc[n][DW-1] ? ff_layer_pkg::FIXED_ZERO : acc[n];
            sum_sq = sum_sq + fx_mul(act[n], act[n]);
        end
    end

    // Partial captured one edge after the sums settle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            partial_valid <= 1'b0;
        end else begin
            partial_valid <= sums_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (sums_ready) begin
            partial <= sum_sq;
        end
    end

    // Weights may only change between samples
    weight_write_idle_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        wload.we |-> (pix_cnt == '0)
    );

    // Samples take at least two pixels, so partial_valid is a lone pulse
    partial_valid_pulse_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        partial_valid |=> !partial_valid
    );

endmodule

// ==== hdl/goodness_combiner.sv ====
// Goodness sum and threshold
`timescale 1ns/1ps
module goodness_combiner #(
    parameter ff_layer_pkg::fixed_t THETA = ff_layer_pkg::THETA_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ff_layer_pkg::fixed_t partial0,
    input  logic                 partial0_valid,
    input  ff_layer_pkg::fixed_t partial1,
    input  logic                 partial1_valid,
    output ff_layer_pkg::fixed_t goodness,
    output logic                 goodness_valid,
    output logic                 is_positive
);

    // Both banks finish on the same edge
    logic                 both_valid;
    // Wrapped total of the two halves
    ff_layer_pkg::fixed_t sum;

    assign both_valid = partial0_valid && partial1_valid;
    assign sum        = partial0 + partial1;

    // Result strobe, one cycle after the partials
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            goodness_valid <= 1'b0;
        end else begin
            goodness_valid <= both_valid;
        end
    end

    // Result word and decision
    // Signed compare, equal to THETA counts as negative
    always_ff @(posedge clk) begin
        if (both_valid) begin
            goodness    <= sum;
            is_positive <= sum > THETA;
        end
    end

    // Banks share one pixel stream, so they must stay in lockstep
    bank_lockstep_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        partial0_valid == partial1_valid
    );

endmodule

// ==== hdl/ff_layer_top.sv ====
// Forward-forward layer top
`timescale 1ns/1ps
module ff_layer_top #(
    parameter int                   INPUT_SIZE  = ff_layer_pkg::INPUT_SIZE,
    parameter int                   NUM_NEURONS = ff_layer_pkg::NUM_NEURONS,
    parameter ff_layer_pkg::fixed_t THETA       = ff_layer_pkg::THETA_DEFAULT
) (
    input  logic                           clk,
    input  logic                           rst_n,
    // Weight write port
    input  logic                           weight_we,
    input  logic [$clog2(NUM_NEURONS)-1:0] weight_neuron,
    input  logic [$clog2(INPUT_SIZE)-1:0]  weight_pixel,
    input  ff_layer_pkg::fixed_t           weight_data,
    // Pixel stream, no back-pressure
    input  logic                           pixel_valid,
    input  ff_layer_pkg::fixed_t           pixel_data,
    // Result, two cycles after the last pixel
    output logic                           goodness_valid,
    output ff_layer_pkg::fixed_t           goodness,
    output logic                           is_positive
);

    // Bank partials into the combiner
    ff_layer_pkg::fixed_t partial0;
    logic                 partial0_valid;
    ff_layer_pkg::fixed_t partial1;
    logic                 partial1_valid;

    weight_load_if #(
        .INPUT_SIZE  (INPUT_SIZE),
        .NUM_NEURONS (NUM_NEURONS)
    ) wload_if ();

    // Weight ports onto the shared write bus
    assign wload_if.we     = weight_we;
    assign wload_if.neuron = weight_neuron;
    assign wload_if.pixel  = weight_pixel;
    assign wload_if.data   = weight_data;

    // Lower half of the neurons
    neuron_bank #(
        .INPUT_SIZE  (INPUT_SIZE),
        .NUM_NEURONS (NUM_NEURONS),
        .BANK_ID     (0)
    ) bank0_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .wload         (wload_if.sink),
        .pixel_valid   (pixel_valid),
        .pixel_data    (pixel_data),
        .partial       (partial0),
        .partial_valid (partial0_valid)
    );

    // Upper half, same pixel stream
    neuron_bank #(
        .INPUT_SIZE  (INPUT_SIZE),
        .NUM_NEURONS (NUM_NEURONS),
        .BANK_ID     (1)
    ) bank1_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .wload         (wload_if.sink),
        .pixel_valid   (pixel_valid),
        .pixel_data    (pixel_data),
        .partial       (partial1),
        .partial_valid (partial1_valid)
    );

    goodness_combiner #(
        .THETA (THETA)
    ) combiner_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .partial0       (partial0),
        .partial0_valid (partial0_valid),
        .partial1       (partial1),
        .partial1_valid (partial1_valid),
        .goodness       (goodness),
        .goodness_valid (goodness_valid),
        .is_positive    (is_positive)
    );

endmodule

// ==== bench/ff_layer_model.svh ====
// Forward-forward layer reference model
`ifndef FF_LAYER_MODEL_SVH
`define FF_LAYER_MODEL_SVH

// Whole weight matrix, neuron first, then pixel
typedef ff_layer_pkg::fixed_t weight_set_t
    [ff_layer_pkg::NUM_NEURONS][ff_layer_pkg::INPUT_SIZE];

// One sample in stream order
typedef ff_layer_pkg::fixed_t sample_t [ff_layer_pkg::INPUT_SIZE];

// Q16.16 product
// Both operands sign-extended to 64 bits, result is bits 47:16
function automatic ff_layer_pkg::fixed_t ref_mul(
    input ff_layer_pkg::fixed_t a,
    input ff_layer_pkg::fixed_t b
);
    logic signed [63:0] wide_a;
    logic signed [63:0] wide_b;
    logic signed [63:0] full;
    wide_a = {{32{a[31]}}, a};
    wide_b = {{32{b[31]}}, b};
    full   = wide_a * wide_b;
    return full[47:16];
endfunction

// Negative activations clamp to zero
function automatic ff_layer_pkg::fixed_t ref_relu(input ff_layer_pkg::fixed_t x);
    return (x < 0) ? '0 : x;
endfunction

// Sum of squared activations over every neuron, all sums wrap
function automatic ff_layer_pkg::fixed_t ref_goodness(
    input weight_set_t w,
    input sample_t     px
);
    ff_layer_pkg::fixed_t acc;
    ff_layer_pkg::fixed_t act;
    ff_layer_pkg::fixed_t total;
    total = '0;
    for (int n = 0; n < ff_layer_pkg::NUM_NEURONS; n++) begin
        acc = '0;
        for (int p = 0; p < ff_layer_pkg::INPUT_SIZE; p++) begin
            acc = acc + ref_mul(px[p], w[n][p]);
        end
        act   = ref_relu(acc);
        total = total + ref_mul(act, act);
    end
    return total;
endfunction

// Strictly above the threshold, signed
function automatic logic ref_positive(input ff_layer_pkg::fixed_t g);
    return g > ff_layer_pkg::THETA_DEFAULT;
endfunction

`endif

// ==== bench/ff_layer_tb.sv ====
// Forward-forward layer testbench
`timescale 1ns/1ps
module ff_layer_tb;

    localparam int NN   = ff_layer_pkg::NUM_NEURONS;
    localparam int NP   = ff_layer_pkg::INPUT_SIZE;
    localparam int NW   = $clog2(NN);
    localparam int PW   = $clog2(NP);
    localparam int HALF = NN / 2;

    // Q16.16 constants for directed samples
    localparam ff_layer_pkg::fixed_t ONE     = 32'sh0001_0000;
    localparam ff_layer_pkg::fixed_t QUARTER = 32'sh0000_4000;

    // Cycles allowed for outstanding results to appear
    localparam int DRAIN_LIMIT = 60;

    `include "ff_layer_model.svh"

    logic                 clk;
    logic                 rst_n;
    logic                 weight_we;
    logic [NW-1:0]        weight_neuron;
    logic [PW-1:0]        weight_pixel;
    ff_layer_pkg::fixed_t weight_data;
    logic                 pixel_valid;
    ff_layer_pkg::fixed_t pixel_data;
    logic                 goodness_valid;
    ff_layer_pkg::fixed_t goodness;
    logic                 is_positive;

    integer seed = 32'h3243;

    // Weights currently held by the DUT, as the model sees them
    weight_set_t cur_w;
    weight_set_t w_set;
    weight_set_t w_ref;
    sample_t     px;

    // Pixel 0 values around THETA, three neurons see 1.0 weights
    ff_layer_pkg::fixed_t theta_probe [5] = '{
        32'sh0000_8000, 32'sh0000_ffff, 32'sh0001_0000, 32'sh0001_0001, 32'sh0002_0000
    };

    // Expected results in issue order
    ff_layer_pkg::fixed_t exp_goodness [$];
    logic                 exp_positive [$];
    int                   samples_sent;
    int                   results_seen;

    ff_layer_top ff_layer_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .weight_we      (weight_we),
        .weight_neuron  (weight_neuron),
        .weight_pixel   (weight_pixel),
        .weight_data    (weight_data),
        .pixel_valid    (pixel_valid),
        .pixel_data     (pixel_data),
        .goodness_valid (goodness_valid),
        .goodness       (goodness),
        .is_positive    (is_positive)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, want);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t: %s", $time, what);
        abort_run();
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Within plus or minus 2.0
    function automatic ff_layer_pkg::fixed_t rand_fixed();
        return $random(seed) % 32'sh0002_0000;
    endfunction

    task automatic randomize_pixels();
        for (int p = 0; p < NP; p++) begin
            px[p] = rand_fixed();
        end
    endtask

    task automatic randomize_weights();
        for (int n = 0; n < NN; n++) begin
            for (int p = 0; p < NP; p++) begin
                w_set[n][p] = rand_fixed();
            end
        end
    endtask

    // One word per cycle through the write port
    task automatic load_weights(input weight_set_t w);
        for (int n = 0; n < NN; n++) begin
            for (int p = 0; p < NP; p++) begin
                weight_we     = 1'b1;
                weight_neuron = NW'(n);
                weight_pixel  = PW'(p);
                weight_data   = w[n][p];
                next_cycle();
            end
        end
        weight_we = 1'b0;
        cur_w     = w;
    endtask

    // Queue the expectation, then stream the pixels with random idle gaps
    task automatic send_sample(input sample_t s, input int max_gap,
                               input ff_layer_pkg::fixed_t want);
        int gap;
        exp_goodness.push_back(want);
        exp_positive.push_back(ref_positive(want));
        samples_sent++;
        for (int p = 0; p < NP; p++) begin
            gap = (max_gap > 0) ? int'({$random(seed)} % (max_gap + 1)) : 0;
            pixel_valid = 1'b0;
            repeat (gap) next_cycle();
            pixel_valid = 1'b1;
            pixel_data  = s[p];
            next_cycle();
        end
        pixel_valid = 1'b0;
    endtask

    task automatic wait_results(input int target);
        int waited;
        waited = 0;
        while (results_seen < target) begin
            if (waited >= DRAIN_LIMIT) begin
                report_problem("timeout waiting for outstanding goodness results");
            end
            next_cycle();
            waited++;
        end
    endtask

    // Compare on the falling edge, where outputs are settled
    initial begin
        ff_layer_pkg::fixed_t want_g;
        logic                 want_p;
        forever begin
            @(negedge clk);
            if (rst_n && goodness_valid) begin
                if (exp_goodness.size() == 0) begin
                    report_problem("goodness_valid pulsed with no sample outstanding");
                end
                want_g = exp_goodness.pop_front();
                want_p = exp_positive.pop_front();
                assert (goodness === want_g)
                    else report_mismatch("goodness", goodness, want_g);
                assert (is_positive === want_p)
                    else report_mismatch("is_positive", {31'b0, is_positive}, {31'b0, want_p});
                results_seen++;
            end
        end
    end

    initial begin
        int lat;
        rst_n         = 1'b0;
        weight_we     = 1'b0;
        weight_neuron = '0;
        weight_pixel  = '0;
        weight_data   = '0;
        pixel_valid   = 1'b0;
        pixel_data    = '0;
        samples_sent  = 0;
        results_seen  = 0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Idle after reset, no result may appear
        repeat (20) begin
            next_cycle();
            assert (!goodness_valid)
                else report_problem("goodness_valid rose with no pixels driven");
        end

        // Uniform weights 1.0 and pixels 0.25, latency measured from the last pixel
        for (int n = 0; n < NN; n++) begin
            for (int p = 0; p < NP; p++) begin
                w_set[n][p] = ONE;
            end
        end
        load_weights(w_set);
        for (int p = 0; p < NP; p++) begin
            px[p] = QUARTER;
        end
        send_sample(px, 0, ref_goodness(cur_w, px));
        lat = 0;
        while (!goodness_valid) begin
            if (lat > 10) begin
                report_problem("timeout waiting for goodness_valid after the last pixel");
            end
            next_cycle();
            lat++;
        end
        assert (lat == 2) else report_mismatch("goodness_valid latency", lat, 2);
        wait_results(samples_sent);

        // Bank 1 driven negative, expected value built from bank 0 rows alone
        for (int n = 0; n < NN; n++) begin
            for (int p = 0; p < NP; p++) begin
                w_set[n][p] = (n < HALF) ? ONE : -ONE;
                w_ref[n][p] = (n < HALF) ? ONE : '0;
            end
        end
        load_weights(w_set);
        send_sample(px, 1, ref_goodness(w_ref, px));
        wait_results(samples_sent);

        // Threshold probes, 1.0 on pixel 0 of three neurons gives exactly 3.0
        for (int n = 0; n < NN; n++) begin
            for (int p = 0; p < NP; p++) begin
                w_set[n][p] = (p == 0 && n < 3) ? ONE : '0;
            end
        end
        load_weights(w_set);
        px[0] = ONE;
        assert (ref_goodness(cur_w, px) == ff_layer_pkg::THETA_DEFAULT)
            else report_problem("threshold probe does not land exactly on THETA");
        for (int i = 0; i < 5; i++) begin
            px[0] = theta_probe[i];
            send_sample(px, 2, ref_goodness(cur_w, px));
        end
        wait_results(samples_sent);

        // Random traffic, back to back and then with gaps
        randomize_weights();
        load_weights(w_set);
        for (int i = 0; i < 20; i++) begin
            randomize_pixels();
            send_sample(px, 0, ref_goodness(cur_w, px));
        end
        for (int i = 0; i < 20; i++) begin
            randomize_pixels();
            send_sample(px, 3, ref_goodness(cur_w, px));
        end
        wait_results(samples_sent);

        // New weights, same last sample must now give another goodness
        w_ref = cur_w;
        randomize_weights();
        assert (ref_goodness(w_set, px) != ref_goodness(w_ref, px))
            else report_problem("reloaded weights predict an unchanged goodness");
        load_weights(w_set);
        send_sample(px, 0, ref_goodness(cur_w, px));
        for (int i = 0; i < 2; i++) begin
            randomize_pixels();
            send_sample(px, 1, ref_goodness(cur_w, px));
        end
        wait_results(samples_sent);

        // Result count must match the sample count
        if (exp_goodness.size() != 0 || results_seen != samples_sent) begin
            report_problem("number of results differs from number of samples");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
+incdir+bench
hdl/ff_layer_pkg.sv
hdl/weight_load_if.sv
hdl/neuron_bank.sv
hdl/goodness_combiner.sv
hdl/ff_layer_top.sv
bench/ff_layer_tb.sv

// ==== Makefile ====
# Verilator flow for the forward-forward layer

VERILATOR ?= verilator
TOP       ?= ff_layer_tb
RTL_TOP   ?= ff_layer_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --timing --assert
PASS_MSG  := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || \
		{ echo "Pass message not found in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
